// ==== sim.f ====
adc_pkg.sv
bitslip_sync.sv
frame_counter.sv
lane_deserializer.sv
sample_fifo.sv
ads5296_unit.sv
tb_ads5296_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it, judge the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ads5296_unit -f sim.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "Test failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "Test passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation clean"

// ==== tb_ads5296_unit.sv ====
`default_nettype none

module tb_ads5296_unit
  import adc_pkg::*;
();

  localparam int n_table_rows  = 3;
  localparam int n_random_rows = 2;
  localparam int n_rows        = n_table_rows + n_random_rows;
  localparam int words_per_idx = 4;  // wr_en window is 4 frames long
  // rows x indices x 40 frames x cycles per frame, plus margin
  localparam int timeout_cycles = n_rows * frame_pairs * 40 * frame_pairs + 1000;

  logic                lclk;
  logic                rst_lclk;
  lane_bits_t          din;
  logic                bitslip;
  logic [2:0]          slip_index;
  logic                wr_en;
  logic                rd_en;
  logic [sample_w-1:0] dout;
  logic                sync_out;
  logic                empty;

  sample_pair_t rows [n_rows];  // stimulus, and the word expected at the aligned index
  sample_pair_t cur_pat;        // pattern the serializer streams
  int unsigned  cycle_cnt;
  int           aligned;
  int           aligned_old;

  ads5296_unit u_dut (
    .lclk       (lclk),
    .rst_lclk   (rst_lclk),
    .din        (din),
    .bitslip    (bitslip),
    .slip_index (slip_index),
    .wr_en      (wr_en),
    .rd_en      (rd_en),
    .dout       (dout),
    .sync_out   (sync_out),
    .empty      (empty)
  );

  initial begin
    lclk = 1'b0;
    forever #50 lclk = ~lclk;
  end

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  // run watchdog
  always @(posedge lclk) begin
    cycle_cnt++;
    if (cycle_cnt > timeout_cycles) begin
      $display("timeout: no end of test after %0d cycles", cycle_cnt);
      abort_run();
    end
  end

  // right rotation by n bit pairs, what a capture n cycles late looks like
  function automatic logic [sample_w-1:0] rotate_lane(input logic [sample_w-1:0] v,
                                                      input int n);
    for (int k = 0; k < n; k++) begin
      v = {v[1:0], v[sample_w-1:2]};
    end
    return v;
  endfunction

  function automatic sample_pair_t rotate_pair(input sample_pair_t p, input int n);
    sample_pair_t r;
    r.lane1 = rotate_lane(p.lane1, n);
    r.lane0 = rotate_lane(p.lane0, n);
    return r;
  endfunction

  function automatic logic rotations_distinct(input sample_pair_t p);
    for (int a = 0; a < frame_pairs; a++) begin
      for (int b = a + 1; b < frame_pairs; b++) begin
        if (rotate_pair(p, a) == rotate_pair(p, b)) return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  function automatic int find_rotation(input sample_pair_t pat, input sample_pair_t got);
    for (int r = 0; r < frame_pairs; r++) begin
      if (rotate_pair(pat, r) == got) return r;
    end
    return -1;  // not a rotation at all
  endfunction

  // serializer model, lsb first, rise bit before fall bit
  task automatic stream_patterns();
    sample_pair_t frame;  // pattern held for a whole frame
    int           pair_idx;
    frame    = '0;
    pair_idx = 0;
    din      = '0;
    forever begin
      @(posedge lclk);
      if (pair_idx == 0) frame = cur_pat;  // new row only at a frame start
      #10;
      din.rise = {frame.lane1[2*pair_idx], frame.lane0[2*pair_idx]};
      din.fall = {frame.lane1[2*pair_idx+1], frame.lane0[2*pair_idx+1]};
      pair_idx = (pair_idx + 1) % frame_pairs;
    end
  endtask

  initial stream_patterns();

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge lclk);
    #10;  // drive point after the edge
  endtask

  task automatic pop_half();
    rd_en = 1'b1;
    wait_cycles(1);
    rd_en = 1'b0;
  endtask

  // index 7 matches no count, so parking there first keeps strobes a frame apart
  task automatic set_index(input logic [2:0] idx);
    slip_index = 3'd7;
    wait_cycles(frame_pairs + 1);
    slip_index = idx;
  endtask

  // hi half then lo half of the head entry
  task automatic read_entry(output sample_pair_t got);
    check_value("empty", 32'(empty), 32'd0);
    check_value("sync_out", 32'(sync_out), 32'd1);
    got.lane1 = dout;
    pop_half();
    check_value("empty", 32'(empty), 32'd0);  // lo half still pending
    check_value("sync_out", 32'(sync_out), 32'd0);
    got.lane0 = dout;
    pop_half();
  endtask

  // sweep 4 down to 0, note the pair rotation seen at each index
  task automatic sweep_row(input sample_pair_t pat, output int aligned_idx);
    sample_pair_t got;
    sample_pair_t exp;
    int           rot [frame_pairs];
    int           n_words;
    int           n_exact;
    n_exact     = 0;
    aligned_idx = 0;
    for (int idx = frame_pairs - 1; idx >= 0; idx--) begin
      set_index(3'(idx));
      wait_cycles(2 * frame_pairs);  // shifters refill with the current row
      wr_en = 1'b1;
      wait_cycles(words_per_idx * frame_pairs);
      wr_en = 1'b0;
      wait_cycles(3);
      n_words  = 0;
      rot[idx] = -1;
      while (empty == 1'b0) begin
        read_entry(got);
        if (n_words == 0) begin
          rot[idx] = find_rotation(pat, got);
          if (rot[idx] < 0) begin
            $display("word %h is no pair rotation of pattern %h", got, pat);
            abort_run();
          end
        end
        exp = rotate_pair(pat, rot[idx]);  // steady pattern, every word alike
        check_value("dout lane1", 32'(got.lane1), 32'(exp.lane1));
        check_value("dout lane0", 32'(got.lane0), 32'(exp.lane0));
        n_words++;
      end
      check_value("words per index", n_words, words_per_idx);
      if (rot[idx] == 0) begin
        n_exact++;
        aligned_idx = idx;
      end
    end
    check_value("unrotated indices", n_exact, 1);
    // a capture k pairs after the aligned one is rotated by k pairs
    for (int idx = 0; idx < frame_pairs; idx++) begin
      check_value("pair rotation", rot[idx],
                  (idx - aligned_idx + frame_pairs) % frame_pairs);
    end
  endtask

  task automatic pulse_bitslip();
    set_index(3'd7);  // no boundary near the held count
    bitslip = 1'b1;
    wait_cycles(8);   // long level, still one slip
    bitslip = 1'b0;
    wait_cycles(frame_pairs);
  endtask

  // more frames than entries, then drain and poke an empty fifo
  task automatic fill_past_full(input sample_pair_t pat, input int aligned_idx);
    sample_pair_t got;
    int           n_halves;
    set_index(3'(aligned_idx));
    wait_cycles(2 * frame_pairs);
    wr_en = 1'b1;
    wait_cycles((fifo_depth + 3) * frame_pairs);
    wr_en = 1'b0;
    wait_cycles(3);
    n_halves = 0;
    while (empty == 1'b0) begin
      read_entry(got);
      check_value("dout lane1", 32'(got.lane1), 32'(pat.lane1));
      check_value("dout lane0", 32'(got.lane0), 32'(pat.lane0));
      n_halves += 2;
    end
    check_value("halves after overflow", n_halves, 2 * fifo_depth);
    repeat (3) begin
      pop_half();
      check_value("empty", 32'(empty), 32'd1);
    end
  endtask

  initial begin
    void'($urandom(32'hb806));
    cycle_cnt  = 0;
    rst_lclk   = 1'b1;
    bitslip    = 1'b0;
    slip_index = 3'd7;
    wr_en      = 1'b0;
    rd_en      = 1'b0;
    cur_pat    = '0;
    rows[0] = {10'h3fe, 10'h001};  // {lane1, lane0}
    rows[1] = {10'h2d4, 10'h00b};
    rows[2] = {10'h31a, 10'h0e3};
    for (int r = n_table_rows; r < n_rows; r++) begin
      for (int tries = 0; tries < 16; tries++) begin
        rows[r].lane0 = sample_w'($urandom);
        rows[r].lane1 = sample_w'($urandom);
        if (rotations_distinct(rows[r])) break;
      end
    end
    for (int r = 0; r < n_rows; r++) begin
      if (!rotations_distinct(rows[r])) begin
        $display("row %0d has repeated pair rotations, alignment is ambiguous", r);
        abort_run();
      end
    end
    cur_pat = rows[0];
    repeat (3) @(posedge lclk);
    #10;
    rst_lclk = 1'b0;
    check_value("empty", 32'(empty), 32'd1);
    slip_index = 3'd0;             // words get framed, only wr_en keeps them out
    wait_cycles(6 * frame_pairs);  // serializer running, wr_en low
    check_value("empty", 32'(empty), 32'd1);
    for (int r = 0; r < n_rows; r++) begin
      cur_pat = rows[r];
      sweep_row(cur_pat, aligned);
      if (r == 0) begin
        aligned_old = aligned;
        pulse_bitslip();
        sweep_row(cur_pat, aligned);
        check_value("aligned index after bitslip", aligned,
                    (aligned_old + frame_pairs - 1) % frame_pairs);
        fill_past_full(cur_pat, aligned);
      end
    end
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== ads5296_unit.sv ====
`default_nettype none

module ads5296_unit
  import adc_pkg::*;
(
  input  logic                lclk,
  input  logic                rst_lclk,
  input  lane_bits_t          din,         // deserialized bit pairs, both lanes
  input  logic                bitslip,     // async level, each rise slips one pair
  input  logic [2:0]          slip_index,  // word phase within the frame
  input  logic                wr_en,
  input  logic                rd_en,
  output logic [sample_w-1:0] dout,
  output logic                sync_out,
  output logic                empty
);

  logic         slip;         // synchronized bitslip strobe
  logic         word_strobe;  // frame boundary
  sample_pair_t word;
  logic         word_valid;

  bitslip_sync u_bitslip_sync (
    .lclk     (lclk),
    .rst_lclk (rst_lclk),
    .bitslip  (bitslip),
    .slip     (slip)
  );

  frame_counter u_frame_counter (
    .lclk        (lclk),
    .rst_lclk    (rst_lclk),
    .slip        (slip),
    .slip_index  (slip_index),
    .word_strobe (word_strobe)
  );

  // bits to framed samples
  lane_deserializer u_lane_deserializer (
    .lclk        (lclk),
    .rst_lclk    (rst_lclk),
    .din         (din),
    .word_strobe (word_strobe),
    .word        (word),
    .word_valid  (word_valid)
  );

  // one entry per pair, read back as two halves
  sample_fifo u_sample_fifo (
    .lclk       (lclk),
    .rst_lclk   (rst_lclk),
    .word       (word),
    .word_valid (word_valid),
    .wr_en      (wr_en),
    .rd_en      (rd_en),
    .dout       (dout),
    .sync_out   (sync_out),
    .empty      (empty)
  );

endmodule

`default_nettype wire

// ==== sample_fifo.sv ====
`default_nettype none

module sample_fifo
  import adc_pkg::*;
(
  input  logic                lclk,
  input  logic                rst_lclk,
  input  sample_pair_t        word,        // framed pair from the deserializer
  input  logic                word_valid,
  input  logic                wr_en,       // software write enable, level
  input  logic                rd_en,       // pop pulse, one half per pulse
  output logic [sample_w-1:0] dout,        // head half, fwft
  output logic                sync_out,    // 1 on the lane 1 half
  output logic                empty
);

  logic [2*slot_w-1:0] mem [fifo_depth];  // raw entries

  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_ptr_w:0]   count;       // occupancy in entries
  logic [fifo_ptr_w:0]   count_next;
  logic                  rd_lo;       // half sequencer: 0 = hi half next, 1 = lo half

  logic        full;
  logic        push;      // accept a new entry
  logic        pop;       // one half consumed
  logic        free;      // whole entry consumed
  fifo_entry_u wr_entry;
  fifo_entry_u rd_entry;
  fifo_slot_t  rd_slot;

  assign full = (count == (fifo_ptr_w + 1)'(fifo_depth));
  assign push = word_valid & wr_en & ~full;  // words while full are dropped
  assign pop  = rd_en & ~empty;              // rd_en while empty is ignored
  assign free = pop & rd_lo;                 // entry leaves after its lo half

  // lane 1 goes out first, tagged by sync
  always_comb begin
    wr_entry.halves.hi.sync   = 1'b1;
    wr_entry.halves.hi.pad    = '0;
    wr_entry.halves.hi.sample = word.lane1;
    wr_entry.halves.lo.sync   = 1'b0;
    wr_entry.halves.lo.pad    = '0;
    wr_entry.halves.lo.sample = word.lane0;
  end

  always_ff @(posedge lclk) begin
    if (push) begin
      mem[wr_ptr] <= wr_entry.raw;
    end
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge lclk) begin
    if (rst_lclk) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      rd_lo  <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (free) rd_ptr <= rd_ptr + 1'b1;
      if (pop)  rd_lo  <= ~rd_lo;  // hi -> lo -> hi
    end
  end

  always_comb begin
    count_next = count;
    if (push && !free) count_next = count + 1'b1;
    if (free && !push) count_next = count - 1'b1;
  end

  // empty is a flag of its own, low the cycle after a write
  always_ff @(posedge lclk) begin
    if (rst_lclk) begin
      count <= '0;
      empty <= 1'b1;
    end else begin
      count <= count_next;
      empty <= (count_next == '0);
    end
  end

  // head entry, half picked by the sequencer
  assign rd_entry.raw = mem[rd_ptr];
  assign rd_slot      = rd_lo ? rd_entry.halves.lo : rd_entry.halves.hi;
  assign dout         = rd_slot.sample;
  assign sync_out     = rd_slot.sync;

  a_count_max: assert property (
    @(posedge lclk) disable iff (rst_lclk)
    count <= (fifo_ptr_w + 1)'(fifo_depth)
  );

  // the registered flag must track the occupancy count
  a_empty_match: assert property (
    @(posedge lclk) disable iff (rst_lclk)
    empty == (count == '0)
  );

endmodule

`default_nettype wire

// ==== lane_deserializer.sv ====
`default_nettype none

module lane_deserializer
  import adc_pkg::*;
(
  input  logic         lclk,
  input  logic         rst_lclk,
  input  lane_bits_t   din,          // rise/fall bits of both lanes
  input  logic         word_strobe,  // frame boundary from the counter
  output sample_pair_t word,         // framed sample pair
  output logic         word_valid    // one cycle, aligned with word
);

  lane_bits_t din_d1;  // input delay, first stage
  lane_bits_t din_d2;  // input delay, second stage

  // one shift register per lane, new pair enters at the top
  logic [sample_w-1:0] shreg [2];

  // two register stages on the pins, kept for timing into the shifters
  always_ff @(posedge lclk) begin
    din_d1 <= din;
    din_d2 <= din_d1;
  end

  // lsb first on the wire, so after frame_pairs shifts the oldest rise bit
  // sits at bit 0 and the newest fall bit at the msb
  always_ff @(posedge lclk) begin
    for (int lane = 0; lane < 2; lane++) begin
      shreg[lane] <= {din_d2.fall[lane], din_d2.rise[lane], shreg[lane][sample_w-1:2]};
    end
  end

  // capture register, payload only
  always_ff @(posedge lclk) begin
    if (word_strobe) begin
      word.lane0 <= shreg[0];
      word.lane1 <= shreg[1];
    end
  end

  // valid follows the strobe by one cycle, same edge as the capture
  always_ff @(posedge lclk) begin
    if (rst_lclk) begin
      word_valid <= 1'b0;
    end else begin
      word_valid <= word_strobe;
    end
  end

  // words are at least frame_pairs cycles apart
  a_valid_spacing: assert property (
    @(posedge lclk) disable iff (rst_lclk)
    word_valid |=> !word_valid [*frame_pairs-1]
  );

endmodule

`default_nettype wire

// ==== frame_counter.sv ====
`default_nettype none

module frame_counter
  import adc_pkg::*;
(
  input  logic       lclk,
  input  logic       rst_lclk,
  input  logic       slip,         // hold the count for one cycle
  input  logic [2:0] slip_index,   // which count marks the frame boundary
  output logic       word_strobe   // capture the shift registers this cycle
);

  logic [2:0] bit_cnt;  // bit pair index within the frame

  // advance once per cycle, wrap at frame_pairs
  // holding on slip delays every later boundary by one pair
  always_ff @(posedge lclk) begin
    if (rst_lclk) begin
      bit_cnt <= 3'd0;
    end else if (!slip) begin
      if (bit_cnt == 3'(frame_pairs - 1)) begin
        bit_cnt <= 3'd0;
      end else begin
        bit_cnt <= bit_cnt + 3'd1;
      end
    end
  end

  // boundary selected by software, combinational
  assign word_strobe = (bit_cnt == slip_index);

  // slip_index 5..7 would never strobe, so the count must stay in range
  a_cnt_range: assert property (
    @(posedge lclk) disable iff (rst_lclk)
    bit_cnt <= 3'(frame_pairs - 1)
  );

  // a strobe can only repeat after a full frame, or one more after a slip
  a_strobe_gap: assert property (
    @(posedge lclk) disable iff (rst_lclk)
    (word_strobe && !slip) |=> !word_strobe
  );

endmodule

`default_nettype wire

// ==== bitslip_sync.sv ====
`default_nettype none

module bitslip_sync (
  input  logic lclk,
  input  logic rst_lclk,
  input  logic bitslip,   // asynchronous level from software
  output logic slip       // one-cycle strobe per rising edge
);

  logic sync_meta;    // first stage, may go metastable
  logic sync_stable;  // second stage, safe to use
  logic level_d;      // edge register

  always_ff @(posedge lclk) begin
    if (rst_lclk) begin
      sync_meta   <= 1'b0;
      sync_stable <= 1'b0;
      level_d     <= 1'b0;
    end else begin
      sync_meta   <= bitslip;
      sync_stable <= sync_meta;
      level_d     <= sync_stable;
    end
  end

  // rising edge of the synchronized level
  assign slip = sync_stable & ~level_d;

  // a held level must give one strobe only, not a train
  a_slip_single: assert property (
    @(posedge lclk) disable iff (rst_lclk)
    slip |=> !slip
  );

endmodule

`default_nettype wire

// ==== adc_pkg.sv ====
`default_nettype none

package adc_pkg;

  // sample framing
  localparam int sample_w    = 10;  // bits per adc sample
  localparam int frame_pairs = 5;   // rise/fall pairs per sample
  localparam int slot_w      = 16;  // one fifo read half
  localparam int pad_w       = slot_w - sample_w - 1;  // zero bits between sync and sample

  // fifo sizing
  localparam int fifo_depth  = 8;   // entries of 2*slot_w bits
  localparam int fifo_ptr_w  = $clog2(fifo_depth);

  // one clock of deserialized input, bit 0 = lane 0, bit 1 = lane 1
  typedef struct packed {
    logic [1:0] rise;  // earlier bit of the pair
    logic [1:0] fall;  // later bit of the pair
  } lane_bits_t;

  // framed output of the deserializer
  typedef struct packed {
    logic [sample_w-1:0] lane1;
    logic [sample_w-1:0] lane0;
  } sample_pair_t;

  // one 16-bit half as seen on the read port
  typedef struct packed {
    logic             sync;    // set on the lane 1 half
    logic [pad_w-1:0] pad;     // always zero
    logic [sample_w-1:0] sample;
  } fifo_slot_t;

  typedef struct packed {
    fifo_slot_t hi;  // read out first
    fifo_slot_t lo;
  } fifo_halves_t;

  // stored as a flat word, packed and unpacked through the halves view
  typedef union packed {
    logic [2*slot_w-1:0] raw;
    fifo_halves_t        halves;
  } fifo_entry_u;

endpackage

`default_nettype wire
